//--- design/alu.sv
`default_nettype none
`timescale 1ns/1ps

`include "dpCore_defines.svh"

module alu (
  input  dpPkg::operandsT       operands,
  input  logic                  previousCflag,
  output logic [`DP_DATA_W-1:0] result,
  output dpPkg::flagsT          aluFlags,
  output logic                  doNotWriteReg
);
  import dpPkg::*;

  aluOpT                 op;
  logic                  reverseInputs;
  logic                  subOp;
  logic                  invertB;
  logic                  aluCarry;
  logic                  arithOp;
  logic [`DP_DATA_W-1:0] a;
  logic [`DP_DATA_W-1:0] b;
  logic [`DP_DATA_W-1:0] condInvB;
  logic [`DP_DATA_W:0]   sum;

  assign op = operands.op;

  // RSB and RSC subtract the other way round
  assign reverseInputs = (op == opRsb) || (op == opRsc);
  assign a = reverseInputs ? operands.bOperand : operands.aOperand;
  assign b = reverseInputs ? operands.aOperand : operands.bOperand;

  always_comb begin
    case (op)
      opSub, opRsb, opSbc, opRsc, opCmp: subOp = 1'b1;
      default:                           subOp = 1'b0;
    endcase
  end

  assign invertB = subOp || (op == opMvn);  // MVN comes out of the adder as 0 + ~b

  always_comb begin
    case (op)
      opSub, opRsb, opCmp: aluCarry = 1'b1;           // Two's complement subtract
      opAdc, opSbc, opRsc: aluCarry = previousCflag;  // Chained with stored C
      default:             aluCarry = 1'b0;
    endcase
  end

  assign condInvB = invertB ? ~b : b;
  assign sum = {1'b0, a} + {1'b0, condInvB} + {{`DP_DATA_W{1'b0}}, aluCarry};

  always_comb begin
    case (op)
      opAnd, opTst: result = a & b;
      opEor, opTeq: result = a ^ b;
      opSub, opRsb,
      opAdd, opAdc,
      opSbc, opRsc,
      opCmp, opCmn: result = sum[`DP_DATA_W-1:0];
      opOrr:        result = a | b;
      opMov, opMvn: result = sum[`DP_DATA_W-1:0];  // A forced to zero upstream
      opBic:        result = a & ~b;
      default:      result = '0;
    endcase
  end

  assign doNotWriteReg = op inside {opTst, opTeq, opCmp, opCmn};

  // Only adder operations produce real C and V
  assign arithOp = op inside {opSub, opRsb, opAdd, opAdc, opSbc, opRsc, opCmp, opCmn};

  assign aluFlags.n = result[`DP_DATA_W-1];
  assign aluFlags.z = (result == '0);
  assign aluFlags.c = arithOp & sum[`DP_DATA_W];
  // Overflow when both adder inputs agree in sign and the sum does not
  assign aluFlags.v = arithOp
                    & ~(a[`DP_DATA_W-1] ^ condInvB[`DP_DATA_W-1])
                    & (a[`DP_DATA_W-1] ^ sum[`DP_DATA_W-1]);

  // A known opcode must give a known result
  always_comb begin
    if (!$isunknown(operands.op)) begin
      assert final (!$isunknown(result))
        else $error("alu: unknown result for opcode %0d", operands.op);
    end
  end

endmodule

`default_nettype wire

//--- design/condUnit.sv
`default_nettype none
`timescale 1ns/1ps

module condUnit (
  input  logic          clk,
  input  logic          rstN,
  input  logic          instrValid,
  input  dpPkg::condT   cond,
  input  dpPkg::aluOpT  op,
  input  logic          setFlags,
  input  logic          doNotWriteReg,
  input  dpPkg::flagsT  aluFlags,
  output dpPkg::flagsT  flags,
  output logic          wbEn
);
  import dpPkg::*;

  logic condPass;
  logic compareOp;
  logic flagWrite;

  // Condition check against the stored flags
  always_comb begin
    case (cond)
      condEq:  condPass = flags.z;
      condNe:  condPass = !flags.z;
      condCs:  condPass = flags.c;
      condCc:  condPass = !flags.c;
      condMi:  condPass = flags.n;
      condPl:  condPass = !flags.n;
      condVs:  condPass = flags.v;
      condVc:  condPass = !flags.v;
      condHi:  condPass = flags.c && !flags.z;
      condLs:  condPass = !flags.c || flags.z;
      condGe:  condPass = (flags.n == flags.v);
      condLt:  condPass = (flags.n != flags.v);
      condGt:  condPass = !flags.z && (flags.n == flags.v);
      condLe:  condPass = flags.z || (flags.n != flags.v);
      condAl:  condPass = 1'b1;
      default: condPass = 1'b0;  // NV
    endcase
  end

  assign compareOp = op inside {opTst, opTeq, opCmp, opCmn};

  assign wbEn      = instrValid && condPass && !doNotWriteReg;
  // Compare-type opcodes set flags even with S clear
  assign flagWrite = instrValid && condPass && (setFlags || compareOp);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else if (flagWrite) begin
      flags <= aluFlags;  // All four replaced together
    end
  end

  // Idle cycles leave the flags alone
  assert property (@(posedge clk) disable iff (!rstN)
    !instrValid |=> $stable(flags))
    else $error("condUnit: flags changed without a valid instruction");

endmodule

`default_nettype wire

//--- design/dpCore.sv
`default_nettype none
`timescale 1ns/1ps

`include "dpCore_defines.svh"

module dpCore (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      instrValid,
  input  dpPkg::dpInstrT            instr,
  output logic                      wbEn,
  output logic [`DP_REG_ADDR_W-1:0] wbAddr,
  output logic [`DP_DATA_W-1:0]     wbData,
  output dpPkg::flagsT              flags
);
  import dpPkg::*;

  logic [`DP_REG_ADDR_W-1:0] readAddrA;
  logic [`DP_REG_ADDR_W-1:0] readAddrB;
  logic [`DP_DATA_W-1:0]     readDataA;
  logic [`DP_DATA_W-1:0]     readDataB;
  operandsT                  operands;
  flagsT                     aluFlags;
  logic                      doNotWriteReg;

  operandUnit uOperandUnit (
    .instr     (instr),
    .readAddrA (readAddrA),
    .readAddrB (readAddrB),
    .readDataA (readDataA),
    .readDataB (readDataB),
    .operands  (operands),
    .destAddr  (wbAddr)
  );

  regFile uRegFile (
    .clk       (clk),
    .rstN      (rstN),
    .readAddrA (readAddrA),
    .readAddrB (readAddrB),
    .readDataA (readDataA),
    .readDataB (readDataB),
    .writeEn   (wbEn),
    .writeAddr (wbAddr),
    .writeData (wbData)
  );

  alu uAlu (
    .operands      (operands),
    .previousCflag (flags.c),  // Stored carry feeds ADC, SBC, RSC
    .result        (wbData),
    .aluFlags      (aluFlags),
    .doNotWriteReg (doNotWriteReg)
  );

  condUnit uCondUnit (
    .clk           (clk),
    .rstN          (rstN),
    .instrValid    (instrValid),
    .cond          (instr.cond),
    .op            (instr.opcode),
    .setFlags      (instr.setFlags),
    .doNotWriteReg (doNotWriteReg),
    .aluFlags      (aluFlags),
    .flags         (flags),
    .wbEn          (wbEn)
  );

endmodule

`default_nettype wire

//--- design/dpPkg.sv
`default_nettype none

`include "dpCore_defines.svh"

package dpPkg;

  // Data-processing opcodes, ARM encoding order
  typedef enum logic [`DP_OPC_W-1:0] {
    opAnd = 4'b0000,
    opEor = 4'b0001,
    opSub = 4'b0010,
    opRsb = 4'b0011,
    opAdd = 4'b0100,
    opAdc = 4'b0101,
    opSbc = 4'b0110,
    opRsc = 4'b0111,
    opTst = 4'b1000,
    opTeq = 4'b1001,
    opCmp = 4'b1010,
    opCmn = 4'b1011,
    opOrr = 4'b1100,
    opMov = 4'b1101,
    opBic = 4'b1110,
    opMvn = 4'b1111
  } aluOpT;

  // Condition field, NV never passes
  typedef enum logic [`DP_COND_W-1:0] {
    condEq, condNe, condCs, condCc,
    condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt,
    condGt, condLe, condAl, condNv
  } condT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // Instruction word, MSB first
  typedef struct packed {
    condT                     cond;
    logic [1:0]               fixedBits;  // Always 00 for data processing, ignored
    logic                     immFlag;
    aluOpT                    opcode;
    logic                     setFlags;
    logic [`DP_REG_ADDR_W-1:0] rn;
    logic [`DP_REG_ADDR_W-1:0] rd;
    logic [`DP_OP2_W-1:0]     operand2;
  } dpInstrT;

  typedef struct packed {
    logic [`DP_DATA_W-1:0] aOperand;
    logic [`DP_DATA_W-1:0] bOperand;
    aluOpT                 op;
  } operandsT;

endpackage

`default_nettype wire

//--- design/operandUnit.sv
`default_nettype none
`timescale 1ns/1ps

`include "dpCore_defines.svh"

module operandUnit (
  input  dpPkg::dpInstrT            instr,
  output logic [`DP_REG_ADDR_W-1:0] readAddrA,
  output logic [`DP_REG_ADDR_W-1:0] readAddrB,
  input  logic [`DP_DATA_W-1:0]     readDataA,
  input  logic [`DP_DATA_W-1:0]     readDataB,
  output dpPkg::operandsT           operands,
  output logic [`DP_REG_ADDR_W-1:0] destAddr
);
  import dpPkg::*;

  logic [3:0]              rotField;
  logic [7:0]              imm8;
  logic [4:0]              rotAmt;
  logic [4:0]              shiftAmt;
  logic [`DP_DATA_W-1:0]   immExt;
  logic [2*`DP_DATA_W-1:0] immDoubled;
  logic [2*`DP_DATA_W-1:0] immShifted;
  logic [`DP_DATA_W-1:0]   immOperand;
  logic [`DP_DATA_W-1:0]   regOperand;
  logic                    moveOp;

  // Field split
  assign rotField  = instr.operand2[11:8];
  assign imm8      = instr.operand2[7:0];
  assign shiftAmt  = instr.operand2[11:7];
  assign readAddrA = instr.rn;
  assign readAddrB = instr.operand2[3:0];  // rm
  assign destAddr  = instr.rd;

  // Rotate right by twice the rotate field
  assign rotAmt     = {rotField, 1'b0};
  assign immExt     = {{(`DP_DATA_W-8){1'b0}}, imm8};
  assign immDoubled = {immExt, immExt};
  assign immShifted = immDoubled >> rotAmt;
  assign immOperand = immShifted[`DP_DATA_W-1:0];

  // Shift type bits 6:5 ignored, only LSL is supported
  assign regOperand = readDataB << shiftAmt;

  assign moveOp = (instr.opcode == opMov) || (instr.opcode == opMvn);

  always_comb begin
    operands.aOperand = moveOp ? '0 : readDataA;  // MOV and MVN pass B through the adder
    operands.bOperand = instr.immFlag ? immOperand : regOperand;
    operands.op       = instr.opcode;
  end

endmodule

`default_nettype wire

//--- design/regFile.sv
`default_nettype none
`timescale 1ns/1ps

`include "dpCore_defines.svh"

module regFile (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic [`DP_REG_ADDR_W-1:0] readAddrA,
  input  logic [`DP_REG_ADDR_W-1:0] readAddrB,
  output logic [`DP_DATA_W-1:0]     readDataA,
  output logic [`DP_DATA_W-1:0]     readDataB,
  input  logic                      writeEn,
  input  logic [`DP_REG_ADDR_W-1:0] writeAddr,
  input  logic [`DP_DATA_W-1:0]     writeData
);

  logic [`DP_DATA_W-1:0] regs [`DP_REG_COUNT];

  // Read ports are combinational, a write shows up on the next cycle
  assign readDataA = regs[readAddrA];
  assign readDataB = regs[readAddrB];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `DP_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[writeAddr] <= writeData;  // Single write port
    end
  end

  // A write must always target a known register
  assert property (@(posedge clk) disable iff (!rstN)
    writeEn |-> !$isunknown(writeAddr))
    else $error("regFile: write enabled with unknown address");

endmodule

`default_nettype wire

//--- include/dpCore_defines.svh
`ifndef DP_CORE_DEFINES_SVH
`define DP_CORE_DEFINES_SVH

// Data path width in bits
`define DP_DATA_W 32

// Architectural register count, r15 is a plain register
`define DP_REG_COUNT 16

// Register address width
`define DP_REG_ADDR_W 4

// Second operand field width in the instruction word
`define DP_OP2_W 12

// Condition and opcode field widths
`define DP_COND_W 4
`define DP_OPC_W 4

`endif

//--- run.sh
#!/bin/sh
# Compile and run the dpCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module dpCoreTb --Mdir obj_dir -o dpCoreSim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/dpCoreSim > "$SIM_LOG" 2>&1
simStatus=$?
cat "$SIM_LOG"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$SIM_LOG"; then
  exit 1
fi
exit 0

//--- sources.f
+incdir+include
design/dpPkg.sv
design/alu.sv
design/regFile.sv
design/operandUnit.sv
design/condUnit.sv
design/dpCore.sv
verification/dpCoreTb.sv

//--- verification/dpCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dpCore_defines.svh"

module dpCoreTb;
  import dpPkg::*;

  localparam int setupCount   = 2 * `DP_REG_COUNT;  // Loads plus read-back moves
  localparam int operandCount = 32;
  localparam int randomCount  = 2000;
  localparam int watchdogNs   = (setupCount + operandCount + randomCount + 16) * 8 + 2000;

  logic                      clk;
  logic                      rstN;
  logic                      instrValid;
  dpInstrT                   instr;
  logic                      wbEn;
  logic [`DP_REG_ADDR_W-1:0] wbAddr;
  logic [`DP_DATA_W-1:0]     wbData;
  flagsT                     flags;

  logic [`DP_DATA_W-1:0] modelRegs [`DP_REG_COUNT];
  flagsT                 modelFlags;
  logic [`DP_DATA_W-1:0] expResult;
  flagsT                 expAluFlags;
  logic                  expWbEn;
  logic                  expFlagWrite;

  string testName;
  int    testChecks;
  int    testErrs;
  int    testsRun;
  int    testsFailed;
  int    totalChecks;
  int    totalErrs;

  dpCore UUT (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .wbEn       (wbEn),
    .wbAddr     (wbAddr),
    .wbData     (wbData),
    .flags      (flags)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    #(watchdogNs);
    $display("Watchdog expired after %0d ns, the run did not finish", watchdogNs);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // 8-bit immediate rotated right by twice the rotate field
  function automatic logic [`DP_DATA_W-1:0] rotatedImm(logic [`DP_OP2_W-1:0] op2);
    logic [`DP_DATA_W-1:0] imm;
    int                    amt;
    imm = {{(`DP_DATA_W-8){1'b0}}, op2[7:0]};
    amt = int'(op2[11:8]) * 2;
    if (amt == 0) begin
      return imm;
    end
    return (imm >> amt) | (imm << (`DP_DATA_W - amt));
  endfunction

  function automatic logic condHolds(condT c, flagsT f);
    case (c)
      condEq:  return f.z;
      condNe:  return !f.z;
      condCs:  return f.c;
      condCc:  return !f.c;
      condMi:  return f.n;
      condPl:  return !f.n;
      condVs:  return f.v;
      condVc:  return !f.v;
      condHi:  return f.c && !f.z;
      condLs:  return !f.c || f.z;
      condGe:  return f.n == f.v;
      condLt:  return f.n != f.v;
      condGt:  return !f.z && (f.n == f.v);
      condLe:  return f.z || (f.n != f.v);
      condAl:  return 1'b1;
      default: return 1'b0;  // NV never
    endcase
  endfunction

  function automatic dpInstrT makeMov(logic immForm, logic [3:0] rd, logic [11:0] op2);
    dpInstrT i;
    i = '0;
    i.cond     = condAl;
    i.immFlag  = immForm;
    i.opcode   = opMov;
    i.rd       = rd;
    i.operand2 = op2;
    return i;
  endfunction

  // Expected result, NZCV, write enable and flag write from the model state
  task automatic predict(input logic valid, input dpInstrT i);
    logic [`DP_DATA_W-1:0] rnVal;
    logic [`DP_DATA_W-1:0] op2Val;
    logic [`DP_DATA_W-1:0] x;
    logic [`DP_DATA_W-1:0] y;
    logic [`DP_DATA_W:0]   sum;
    logic                  cin;
    logic                  arith;
    logic                  compare;
    logic                  pass;
    rnVal = modelRegs[i.rn];
    if (i.immFlag) begin
      op2Val = rotatedImm(i.operand2);
    end else begin
      op2Val = modelRegs[i.operand2[3:0]] << i.operand2[11:7];  // LSL only
    end
    arith = 1'b1;
    x     = rnVal;
    y     = op2Val;
    cin   = 1'b0;
    case (i.opcode)
      opAnd, opTst: begin
        arith     = 1'b0;
        expResult = rnVal & op2Val;
      end
      opEor, opTeq: begin
        arith     = 1'b0;
        expResult = rnVal ^ op2Val;
      end
      opOrr: begin
        arith     = 1'b0;
        expResult = rnVal | op2Val;
      end
      opBic: begin
        arith     = 1'b0;
        expResult = rnVal & ~op2Val;
      end
      opMov: begin
        arith     = 1'b0;
        expResult = op2Val;
      end
      opMvn: begin
        arith     = 1'b0;
        expResult = ~op2Val;
      end
      opAdd, opCmn: cin = 1'b0;
      opAdc:        cin = modelFlags.c;
      opSub, opCmp: begin
        y   = ~op2Val;
        cin = 1'b1;
      end
      opSbc: begin
        y   = ~op2Val;
        cin = modelFlags.c;
      end
      opRsb: begin
        x   = op2Val;  // Reversed subtract
        y   = ~rnVal;
        cin = 1'b1;
      end
      default: begin  // RSC
        x   = op2Val;
        y   = ~rnVal;
        cin = modelFlags.c;
      end
    endcase
    sum = {1'b0, x} + {1'b0, y} + {{`DP_DATA_W{1'b0}}, cin};
    if (arith) begin
      expResult = sum[`DP_DATA_W-1:0];
    end
    expAluFlags.n = expResult[`DP_DATA_W-1];
    expAluFlags.z = (expResult == '0);
    expAluFlags.c = arith && sum[`DP_DATA_W];
    expAluFlags.v = arith && (x[`DP_DATA_W-1] == y[`DP_DATA_W-1])
                  && (expResult[`DP_DATA_W-1] != x[`DP_DATA_W-1]);
    compare      = i.opcode inside {opTst, opTeq, opCmp, opCmn};
    pass         = condHolds(i.cond, modelFlags);
    expWbEn      = valid && pass && !compare;
    expFlagWrite = valid && pass && (i.setFlags || compare);
  endtask

  task automatic checkValue(input string what, input logic [31:0] exp, input logic [31:0] act);
    testChecks++;
    assert (exp === act) else begin
      $display("ERR %s %s expected %h actual %h", testName, what, exp, act);
      testErrs++;
    end
  endtask

  // One instruction per cycle, model follows the rising edge
  task automatic runInstr(input logic valid, input dpInstrT i);
    @(negedge clk);
    checkValue("flags", 32'(modelFlags), 32'(flags));
    instrValid = valid;
    instr      = i;
    predict(valid, i);
    #1;
    checkValue("wbEn", 32'(expWbEn), 32'(wbEn));
    if (expWbEn) begin
      checkValue("wbAddr", 32'(i.rd), 32'(wbAddr));
      checkValue("wbData", expResult, wbData);
    end
    @(posedge clk);
    if (expWbEn) begin
      modelRegs[i.rd] = expResult;
    end
    if (expFlagWrite) begin
      modelFlags = expAluFlags;
    end
  endtask

  task automatic startTest(input string name);
    testName   = name;
    testChecks = 0;
    testErrs   = 0;
  endtask

  task automatic finishTest();
    @(negedge clk);
    checkValue("flags", 32'(modelFlags), 32'(flags));  // Last edge of the test
    instrValid = 1'b0;
    testsRun++;
    totalChecks += testChecks;
    totalErrs   += testErrs;
    if (testErrs != 0) begin
      testsFailed++;
    end
    $display("%s finished: %0d checks, %0d errors", testName, testChecks, testErrs);
  endtask

  initial begin
    dpInstrT rnd;
    void'($urandom(29));
    rstN        = 1'b0;
    instrValid  = 1'b0;
    instr       = '0;
    modelFlags  = '0;
    testsRun    = 0;
    testsFailed = 0;
    totalChecks = 0;
    totalErrs   = 0;
    for (int r = 0; r < `DP_REG_COUNT; r++) begin
      modelRegs[r] = '0;
    end

    startTest("reset");
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    for (int k = 0; k < 4; k++) begin
      runInstr(1'b0, dpInstrT'($urandom));  // Idle, wbEn must stay low
    end
    finishTest();

    startTest("regLoad");
    for (int r = 0; r < `DP_REG_COUNT; r++) begin
      runInstr(1'b1, makeMov(1'b1, 4'(r), 12'($urandom)));
    end
    for (int r = 0; r < `DP_REG_COUNT; r++) begin
      runInstr(1'b1, makeMov(1'b0, 4'(r), {8'h00, 4'(r)}));  // Read back, shift 0
    end
    finishTest();

    startTest("operand2");
    for (int k = 0; k < operandCount / 2; k++) begin
      runInstr(1'b1, makeMov(1'b1, 4'(k), {4'(k), 8'(($urandom % 255) + 1)}));
      runInstr(1'b1, makeMov(1'b0, 4'(15 - k), {5'(2 * k + 1), 3'b000, 4'(k)}));
    end
    finishTest();

    startTest("randomRun");
    for (int k = 0; k < randomCount; k++) begin
      rnd = dpInstrT'($urandom);
      runInstr(($urandom % 8) != 0, rnd);  // About one idle slot in eight
    end
    finishTest();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             testsRun, testsFailed, totalChecks, totalErrs);
    if (testsFailed == 0 && totalErrs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
